// ==== source/buffer_cfg_pkg.sv ====
package buffer_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // queues and stream words
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_QUEUES = 4;
    localparam int QUEUE_ID_WIDTH = $clog2(NUM_QUEUES);
    localparam int WORD_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // shared buffer memory
    //////////////////////////////////////////////////////////////////////

    // one fixed circular region per queue
    localparam int REGION_DEPTH = 16;
    localparam int MEM_DEPTH = NUM_QUEUES * REGION_DEPTH;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);
    localparam int REGION_PTR_WIDTH = $clog2(REGION_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // ingress and egress fifos
    //////////////////////////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 4;
    // one extra bit so a full fifo can report FIFO_DEPTH
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH) + 1;

endpackage

// ==== source/multi_queue_buffer.sv ====
`timescale 1ns/1ps

module multi_queue_buffer
(
    input  logic                                                  clk,
    input  logic                                                  aresetn,
    input  stream_pkg::stream_word_t [buffer_cfg_pkg::NUM_QUEUES-1:0] in_word,
    input  logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 in_valid,
    output logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 in_ready,
    output stream_pkg::stream_word_t [buffer_cfg_pkg::NUM_QUEUES-1:0] out_word,
    output logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 out_valid,
    input  logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 out_ready
);

    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                ingress_empty;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                ingress_full;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                ingress_pop;
    stream_pkg::stream_word_t [buffer_cfg_pkg::NUM_QUEUES-1:0] ingress_word;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                egress_empty;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                egress_push;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]
          [buffer_cfg_pkg::FIFO_COUNT_WIDTH-1:0]          egress_count;
    stream_pkg::mem_write_t                               mem_wr;
    stream_pkg::mem_read_t                                mem_rd;
    stream_pkg::stream_word_t                             mem_rd_word;

    //////////////////////////////////////////////////////////////////////
    // per-queue ingress and egress fifos
    //////////////////////////////////////////////////////////////////////

    for (genvar q = 0; q < buffer_cfg_pkg::NUM_QUEUES; q++)
    begin : queue_slot
        // stream side handshakes
        assign in_ready[q] = !ingress_full[q];
        assign out_valid[q] = !egress_empty[q];

        word_fifo ingress_fifo
        (
            .clk     (clk),
            .aresetn (aresetn),
            .push    (in_valid[q] && in_ready[q]),
            .pop     (ingress_pop[q]),
            .wdata   (in_word[q]),
            .rdata   (ingress_word[q]),
            .full    (ingress_full[q]),
            .empty   (ingress_empty[q]),
            .count   ()
        );

        // fed from the shared read port, room checked by the controller
        word_fifo egress_fifo
        (
            .clk     (clk),
            .aresetn (aresetn),
            .push    (egress_push[q]),
            .pop     (out_valid[q] && out_ready[q]),
            .wdata   (mem_rd_word),
            .rdata   (out_word[q]),
            .full    (),
            .empty   (egress_empty[q]),
            .count   (egress_count[q])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // shared memory and controller
    //////////////////////////////////////////////////////////////////////

    queue_memory buffer_mem
    (
        .clk     (clk),
        .wr      (mem_wr),
        .rd      (mem_rd),
        .rd_word (mem_rd_word)
    );

    queue_controller controller
    (
        .clk           (clk),
        .aresetn       (aresetn),
        .ingress_empty (ingress_empty),
        .ingress_word  (ingress_word),
        .ingress_pop   (ingress_pop),
        .egress_count  (egress_count),
        .egress_push   (egress_push),
        .mem_wr        (mem_wr),
        .mem_rd        (mem_rd)
    );

endmodule

// ==== source/queue_controller.sv ====
`timescale 1ns/1ps

module queue_controller
(
    input  logic                                                  clk,
    input  logic                                                  aresetn,
    input  logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 ingress_empty,
    input  stream_pkg::stream_word_t [buffer_cfg_pkg::NUM_QUEUES-1:0] ingress_word,
    output logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 ingress_pop,
    input  logic [buffer_cfg_pkg::NUM_QUEUES-1:0]
                 [buffer_cfg_pkg::FIFO_COUNT_WIDTH-1:0]           egress_count,
    output logic [buffer_cfg_pkg::NUM_QUEUES-1:0]                 egress_push,
    output stream_pkg::mem_write_t                                mem_wr,
    output stream_pkg::mem_read_t                                 mem_rd
);

    // circular queue state of one region
    typedef struct packed {
        logic [buffer_cfg_pkg::REGION_PTR_WIDTH-1:0] head;
        logic [buffer_cfg_pkg::REGION_PTR_WIDTH-1:0] tail;
        logic [buffer_cfg_pkg::REGION_PTR_WIDTH:0]   count;
    } region_t;

    // arbiter result
    typedef struct packed {
        logic                                      valid;
        logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] id;
    } grant_t;

    region_t [buffer_cfg_pkg::NUM_QUEUES-1:0]  region;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]     wr_eligible;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]     rd_eligible;
    logic [buffer_cfg_pkg::NUM_QUEUES-1:0]     rd_hit;
    grant_t                                    wr_grant;
    grant_t                                    rd_grant;
    logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] last_wr;
    logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] last_rd;
    logic                                      rd_inflight;
    logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] rd_inflight_id;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // round robin, search starts one past the last grant
    function automatic grant_t rr_pick
    (
        input logic [buffer_cfg_pkg::NUM_QUEUES-1:0]     eligible,
        input logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] last
    );
        grant_t                                    pick;
        logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0] idx;
        pick = '0;
        // walk from the far end so the nearest candidate wins
        for (int i = buffer_cfg_pkg::NUM_QUEUES; i >= 1; i--)
        begin
            idx = last + i[buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0];
            if (eligible[idx])
            begin
                pick.valid = 1'b1;
                pick.id = idx;
            end
        end
        return pick;
    endfunction

    // region base is queue id times REGION_DEPTH, so the id fills the top bits
    function automatic logic [buffer_cfg_pkg::MEM_ADDR_WIDTH-1:0] region_addr
    (
        input logic [buffer_cfg_pkg::QUEUE_ID_WIDTH-1:0]   id,
        input logic [buffer_cfg_pkg::REGION_PTR_WIDTH-1:0] ptr
    );
        return {id, ptr};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // eligibility and grants
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int q = 0; q < buffer_cfg_pkg::NUM_QUEUES; q++)
        begin
            wr_eligible[q] = !ingress_empty[q]
                && (region[q].count != buffer_cfg_pkg::REGION_DEPTH);
            // the outstanding read already holds one egress slot
            if (rd_inflight && (rd_inflight_id == q))
                rd_eligible[q] = (region[q].count != 0)
                    && (egress_count[q] < buffer_cfg_pkg::FIFO_DEPTH - 1);
            else
                rd_eligible[q] = (region[q].count != 0)
                    && (egress_count[q] < buffer_cfg_pkg::FIFO_DEPTH);
        end
    end

    assign wr_grant = rr_pick(wr_eligible, last_wr);
    assign rd_grant = rr_pick(rd_eligible, last_rd);

    always_comb
    begin
        for (int q = 0; q < buffer_cfg_pkg::NUM_QUEUES; q++)
        begin
            ingress_pop[q] = wr_grant.valid && (wr_grant.id == q);
            rd_hit[q] = rd_grant.valid && (rd_grant.id == q);
            // read data lands one cycle after the request
            egress_push[q] = rd_inflight && (rd_inflight_id == q);
        end
    end

    // ingress head goes straight to the tail slot of its region
    always_comb
    begin
        mem_wr.en = wr_grant.valid;
        mem_wr.addr = region_addr(wr_grant.id, region[wr_grant.id].tail);
        mem_wr.word = ingress_word[wr_grant.id];
        mem_rd.en = rd_grant.valid;
        mem_rd.addr = region_addr(rd_grant.id, region[rd_grant.id].head);
    end

    //////////////////////////////////////////////////////////////////////
    // region pointers and arbiter state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            region <= '0;
            last_wr <= '0;
            last_rd <= '0;
            rd_inflight <= 1'b0;
            rd_inflight_id <= '0;
        end
        else
        begin
            for (int q = 0; q < buffer_cfg_pkg::NUM_QUEUES; q++)
            begin
                if (ingress_pop[q])
                    region[q].tail <= region[q].tail + 1'b1;
                if (rd_hit[q])
                    region[q].head <= region[q].head + 1'b1;
                // a write and a read together leave the count alone
                if (ingress_pop[q] && !rd_hit[q])
                    region[q].count <= region[q].count + 1'b1;
                else if (rd_hit[q] && !ingress_pop[q])
                    region[q].count <= region[q].count - 1'b1;
            end
            if (wr_grant.valid)
                last_wr <= wr_grant.id;
            if (rd_grant.valid)
                last_rd <= rd_grant.id;
            rd_inflight <= rd_grant.valid;
            rd_inflight_id <= rd_grant.id;
        end
    end

endmodule

// ==== source/queue_memory.sv ====
`timescale 1ns/1ps

module queue_memory
(
    input  logic                     clk,
    input  stream_pkg::mem_write_t   wr,
    input  stream_pkg::mem_read_t    rd,
    output stream_pkg::stream_word_t rd_word
);

    //////////////////////////////////////////////////////////////////////
    // storage for all four regions
    //////////////////////////////////////////////////////////////////////

    stream_pkg::stream_word_t mem [buffer_cfg_pkg::MEM_DEPTH];

    // write port
    always_ff @(posedge clk)
    begin
        if (wr.en)
            mem[wr.addr] <= wr.word;
    end

    // registered read port, one cycle of latency
    // a same-cycle write to rd.addr is seen from the next read on
    always_ff @(posedge clk)
    begin
        if (rd.en)
            rd_word <= mem[rd.addr];
    end

endmodule

// ==== source/stream_pkg.sv ====
package stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream payload
    //////////////////////////////////////////////////////////////////////

    // one word of a packet, last marks end of packet
    typedef struct packed {
        logic [buffer_cfg_pkg::WORD_WIDTH-1:0] data;
        logic                                  last;
    } stream_word_t;

    //////////////////////////////////////////////////////////////////////
    // buffer memory ports
    //////////////////////////////////////////////////////////////////////

    // write request, takes effect at the clock edge
    typedef struct packed {
        logic                                      en;
        logic [buffer_cfg_pkg::MEM_ADDR_WIDTH-1:0] addr;
        stream_word_t                              word;
    } mem_write_t;

    // read request, word comes back one cycle later
    typedef struct packed {
        logic                                      en;
        logic [buffer_cfg_pkg::MEM_ADDR_WIDTH-1:0] addr;
    } mem_read_t;

endpackage

// ==== source/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo
(
    input  logic                                        clk,
    input  logic                                        aresetn,
    input  logic                                        push,
    input  logic                                        pop,
    input  stream_pkg::stream_word_t                    wdata,
    output stream_pkg::stream_word_t                    rdata,
    output logic                                        full,
    output logic                                        empty,
    output logic [buffer_cfg_pkg::FIFO_COUNT_WIDTH-1:0] count
);

    stream_pkg::stream_word_t entries [buffer_cfg_pkg::FIFO_DEPTH];

    // pointers wrap on their own, depth is a power of two
    logic [$clog2(buffer_cfg_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(buffer_cfg_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [buffer_cfg_pkg::FIFO_COUNT_WIDTH-1:0]   count_next;
    logic                                          do_push;
    logic                                          do_pop;

    // push on full and pop on empty are dropped here
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // head of the queue, visible without a pop
    assign rdata = entries[rd_ptr];

    always_comb
    begin
        count_next = count;
        if (do_push && !do_pop)
            count_next = count + 1'b1;
        else if (do_pop && !do_push)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            entries[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            // flags follow the next count, so they stay registered
            full <= (count_next == buffer_cfg_pkg::FIFO_DEPTH);
            empty <= (count_next == 0);
        end
    end

endmodule

// ==== sources.f ====
source/buffer_cfg_pkg.sv
source/stream_pkg.sv
source/word_fifo.sv
source/queue_memory.sv
source/queue_controller.sv
source/multi_queue_buffer.sv
tests/multi_queue_buffer_tb.sv

// ==== tests/multi_queue_buffer_tb.sv ====
`timescale 1ns/1ps

module multi_queue_buffer_tb;

    localparam int NQ = buffer_cfg_pkg::NUM_QUEUES;
    localparam int STALL_LIMIT = buffer_cfg_pkg::REGION_DEPTH + 2 * buffer_cfg_pkg::FIFO_DEPTH;
    // total words of all tests for the watchdog limit
    localparam int TOTAL_WORDS = 40 + 4 * 48 + 3 * 32 + 40;
    localparam longint WATCHDOG_NS = 20 * TOTAL_WORDS * 8;

    logic                                clk;
    logic                                aresetn;
    stream_pkg::stream_word_t [NQ-1:0]   in_word;
    logic [NQ-1:0]                       in_valid;
    logic [NQ-1:0]                       in_ready;
    stream_pkg::stream_word_t [NQ-1:0]   out_word;
    logic [NQ-1:0]                       out_valid;
    logic [NQ-1:0]                       out_ready;

    int          sent [NQ];
    int          recv [NQ];
    int          ready_mode [NQ];
    logic [31:0] valid_rng [NQ];
    logic [31:0] ready_rng [NQ];
    int          errors;
    int          tests_passed;
    int          tests_failed;

    multi_queue_buffer multi_queue_buffer_inst
    (
        .clk       (clk),
        .aresetn   (aresetn),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model and random source
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // queue index in the top byte, sequence number below, last on every eighth word
    function automatic stream_pkg::stream_word_t expected_word(input int q, input int seq);
        stream_pkg::stream_word_t word;
        word.data = (q << 24) | (seq & 32'h00ff_ffff);
        word.last = ((seq % 8) == 7);
        return word;
    endfunction

    task automatic send_words(input int q, input int n, input bit gaps);
        int accepted;
        accepted = 0;
        while (accepted < n)
        begin
            @(negedge clk);
            valid_rng[q] = lcg_next(valid_rng[q]);
            if (!gaps || (valid_rng[q][31:30] != 2'b00))
            begin
                in_word[q] = expected_word(q, sent[q]);
                in_valid[q] = 1'b1;
            end
            else
                in_valid[q] = 1'b0;
            @(posedge clk);
            if (in_valid[q] && in_ready[q])
            begin
                sent[q]++;
                accepted++;
            end
        end
        @(negedge clk);
        in_valid[q] = 1'b0;
    endtask

    task automatic wait_drained();
        for (int q = 0; q < NQ; q++)
            while (recv[q] != sent[q])
                @(negedge clk);
    endtask

    task automatic finish_test(input int num, input string name, input int errors_before);
        if (errors == errors_before)
        begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: fail", num, name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output ready and output checking
    //////////////////////////////////////////////////////////////////////

    // mode 0 holds ready high, 1 gives random gaps, 2 holds it low
    always @(negedge clk)
    begin
        for (int q = 0; q < NQ; q++)
        begin
            ready_rng[q] = lcg_next(ready_rng[q]);
            case (ready_mode[q])
                0: out_ready[q] = 1'b1;
                1: out_ready[q] = (ready_rng[q][31:30] != 2'b00);
                default: out_ready[q] = 1'b0;
            endcase
        end
    end

    always @(posedge clk)
    begin : check_outputs
        stream_pkg::stream_word_t expected;
        if (aresetn)
        begin
            for (int q = 0; q < NQ; q++)
            begin
                if (out_valid[q] && out_ready[q])
                begin
                    expected = expected_word(q, recv[q]);
                    assert (recv[q] < sent[q])
                    else
                    begin
                        $display("queue %0d delivered a word that was never sent", q);
                        errors++;
                    end
                    assert (out_word[q] == expected)
                    else
                    begin
                        $display("CHECK FAILED time=%0t signal=out_word[%0d] expected=%h actual=%h",
                            $time, q, expected, out_word[q]);
                        errors++;
                    end
                    recv[q]++;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished, the DUT stopped moving words");
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int errors_before;
        int base;
        clk = 1'b0;
        aresetn = 1'b0;
        in_word = '0;
        in_valid = '0;
        out_ready = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        valid_rng[0] = 32'd95526;
        ready_rng[0] = lcg_next(valid_rng[0]);
        for (int q = 0; q < NQ; q++)
        begin
            if (q > 0)
            begin
                valid_rng[q] = lcg_next(ready_rng[q-1]);
                ready_rng[q] = lcg_next(valid_rng[q]);
            end
            sent[q] = 0;
            recv[q] = 0;
            ready_mode[q] = 0;
        end
        repeat (10) @(negedge clk);
        aresetn = 1'b1;

        // first cycle out of reset
        errors_before = errors;
        @(negedge clk);
        assert (out_valid == '0)
        else
        begin
            $display("CHECK FAILED time=%0t signal=out_valid expected=%b actual=%b",
                $time, {NQ{1'b0}}, out_valid);
            errors++;
        end
        assert (in_ready == '1)
        else
        begin
            $display("CHECK FAILED time=%0t signal=in_ready expected=%b actual=%b",
                $time, {NQ{1'b1}}, in_ready);
            errors++;
        end
        finish_test(1, "reset", errors_before);

        errors_before = errors;
        send_words(0, 40, 1'b0);
        wait_drained();
        // nothing left behind once the whole sequence is out
        assert (out_valid[0] == 1'b0)
        else
        begin
            $display("CHECK FAILED time=%0t signal=out_valid[0] expected=0 actual=%b",
                $time, out_valid[0]);
            errors++;
        end
        finish_test(2, "single queue order", errors_before);

        errors_before = errors;
        for (int q = 0; q < NQ; q++)
            ready_mode[q] = 1;
        fork
            send_words(0, 48, 1'b1);
            send_words(1, 48, 1'b1);
            send_words(2, 48, 1'b1);
            send_words(3, 48, 1'b1);
        join
        wait_drained();
        finish_test(3, "concurrent traffic", errors_before);

        // queue 2 stalls while the others keep going
        errors_before = errors;
        base = sent[2];
        ready_mode[2] = 2;
        fork
            send_words(2, 40, 1'b0);
        join_none
        fork
            send_words(0, 32, 1'b1);
            send_words(1, 32, 1'b1);
            send_words(3, 32, 1'b1);
        join
        while ((recv[0] != sent[0]) || (recv[1] != sent[1]) || (recv[3] != sent[3]))
            @(negedge clk);
        while (in_ready[2])
            @(negedge clk);
        assert (sent[2] - base <= STALL_LIMIT)
        else
        begin
            $display("queue 2 accepted %0d words while stalled, more than %0d",
                sent[2] - base, STALL_LIMIT);
            errors++;
        end
        // stalled words wait at the egress side
        assert (out_valid[2] == 1'b1)
        else
        begin
            $display("CHECK FAILED time=%0t signal=out_valid[2] expected=1 actual=%b",
                $time, out_valid[2]);
            errors++;
        end
        finish_test(4, "queue isolation", errors_before);

        errors_before = errors;
        ready_mode[2] = 0;
        while (sent[2] != base + 40)
            @(negedge clk);
        wait_drained();
        finish_test(5, "drain", errors_before);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
